// ==== common/gpbb_bus_pkg.sv ====
// widths and types of the EIM multiplexed address/data bus
// imported by every block that touches the CPU side of the register map

package gpbb_bus_pkg;

   //////////////////////////////
   // bus widths
   //////////////////////////////

   // one word on the shared address/data lines
   localparam int EIM_DATA_W = 16;

   // full byte address as seen by the register map
   localparam int EIM_ADDR_W = 19;

   // low address bits arrive on the data lines during the address phase
   localparam int EIM_ADDR_LO_BITS = 16;

   // remaining upper bits come from the dedicated address pins
   localparam int EIM_HI_ADDR_W = EIM_ADDR_W - EIM_ADDR_LO_BITS;

   //////////////////////////////
   // pipeline depths
   //////////////////////////////

   // read data retiming registers between the decode and the pins
   // (kept close to the pads so the wire delay gets most of the cycle)
   localparam int EIM_RD_STAGES = 2;

   //////////////////////////////
   // types
   //////////////////////////////

   // data word driven or sampled on the da lines
   typedef logic [EIM_DATA_W-1:0] eim_data_t;

   // latched byte address
   // top bits from a_i and low bits from the data lines
   typedef logic [EIM_ADDR_W-1:0] eim_addr_t;

   // upper address pins only
   typedef logic [EIM_HI_ADDR_W-1:0] eim_hi_addr_t;

endpackage

// ==== common/gpbb_map_pkg.sv ====
// register map of the breakout board: addresses, bit positions and version codes
// used by the register block and by the testbench to address the same words

package gpbb_map_pkg;

   //////////////////////////////
   // DUT side
   //////////////////////////////

   // one bank of DUT pins is one byte wide
   localparam int DUT_BYTE_W = 8;

   typedef logic [DUT_BYTE_W-1:0] dut_byte_t;

   //////////////////////////////
   // write-only bank
   //////////////////////////////

   // board control word
   localparam gpbb_bus_pkg::eim_addr_t ADDR_CTL = 19'h4_0000;

   // data for both DUT output banks
   // low byte goes to bank A and high byte to bank B
   localparam gpbb_bus_pkg::eim_addr_t ADDR_DUT_OUT = 19'h4_0002;

   //////////////////////////////
   // read-only bank
   //////////////////////////////

   // synchronized DUT input byte, zero extended
   localparam gpbb_bus_pkg::eim_addr_t ADDR_DUT_IN = 19'h4_1000;

   // board status flags
   localparam gpbb_bus_pkg::eim_addr_t ADDR_STAT = 19'h4_1002;

   // version words sit at the very top of the read-only bank
   localparam gpbb_bus_pkg::eim_addr_t ADDR_VER_MINOR = 19'h4_1FFC;
   localparam gpbb_bus_pkg::eim_addr_t ADDR_VER_MAJOR = 19'h4_1FFE;

   //////////////////////////////
   // field positions
   //////////////////////////////

   // control word bits, set to 1 from software to enable the function
   localparam int CTL_DRIVE_A = 0;
   localparam int CTL_DRIVE_B = 1;
   // 1 selects 5V output levels, 0 keeps the low voltage default
   localparam int CTL_HIGH_V = 15;

   // status word bits
   localparam int STAT_OVERCURRENT = 0;

   //////////////////////////////
   // version codes
   //////////////////////////////

   // major code identifies the design type, minor tracks its revision
   localparam gpbb_bus_pkg::eim_data_t VER_MINOR = 16'h0003;
   localparam gpbb_bus_pkg::eim_data_t VER_MAJOR = 16'h000B;

endpackage

// ==== eim/eim_capture.sv ====
// front end of the EIM bus: registers the pins, latches the address
// and derives the write strobe and the read drive qualifier

module eim_capture (
   input  logic                       bclk_i,
   input  logic                       arst_n_i,
   input  logic                       cs_n_i,
   input  logic                       rw_i,
   input  logic                       lba_n_i,
   input  logic                       oe_n_i,
   input  gpbb_bus_pkg::eim_hi_addr_t a_i,
   input  gpbb_bus_pkg::eim_data_t    da_i,
   output gpbb_bus_pkg::eim_addr_t    bus_addr_o,
   output gpbb_bus_pkg::eim_data_t    wr_data_o,
   output logic                       wr_stb_o,
   output logic                       rd_drive_o
);

   import gpbb_bus_pkg::*;

   // stage 1 of the input pipeline
   logic         cs_n_s1;
   logic         rw_s1;
   logic         lba_n_s1;
   logic         oe_n_s1;
   eim_hi_addr_t a_s1;
   eim_data_t    da_s1;

   // stage 2, only the signals the write path needs
   logic         cs_n_s2;
   logic         rw_s2;
   logic         lba_n_s2;
   eim_data_t    da_s2;

   eim_addr_t    bus_addr_q;

   //////////////////////////////
   // input pipeline
   //////////////////////////////

   // two register stages give the pads a full cycle for setup and hold
   // control lines reset to their idle levels so no cycle is seen
   always_ff @(posedge bclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cs_n_s1  <= 1'b1;
         rw_s1    <= 1'b1;
         lba_n_s1 <= 1'b1;
         oe_n_s1  <= 1'b1;
         a_s1     <= '0;
         da_s1    <= '0;
         cs_n_s2  <= 1'b1;
         rw_s2    <= 1'b1;
         lba_n_s2 <= 1'b1;
         da_s2    <= '0;
      end else begin
         cs_n_s1  <= cs_n_i;
         rw_s1    <= rw_i;
         lba_n_s1 <= lba_n_i;
         oe_n_s1  <= oe_n_i;
         a_s1     <= a_i;
         da_s1    <= da_i;
         cs_n_s2  <= cs_n_s1;
         rw_s2    <= rw_s1;
         lba_n_s2 <= lba_n_s1;
         da_s2    <= da_s1;
      end
   end

   //////////////////////////////
   // address latch
   //////////////////////////////

   // address phase = lba_n low while selected
   // the address then holds for all data beats of the cycle
   always_ff @(posedge bclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bus_addr_q <= '0;
      end else if (!cs_n_s1 && !lba_n_s1) begin
         bus_addr_q[EIM_ADDR_LO_BITS-1:0]          <= da_s1;
         bus_addr_q[EIM_ADDR_W-1:EIM_ADDR_LO_BITS] <= a_s1;
      end
   end

   assign bus_addr_o = bus_addr_q;

   //////////////////////////////
   // beat qualification
   //////////////////////////////

   // one strobe per write beat in stage 2
   // lands a cycle after the address so a back-to-back address phase
   // cannot overtake the last beat of the previous write
   assign wr_stb_o  = !cs_n_s2 && !rw_s2 && lba_n_s2;
   assign wr_data_o = da_s2;

   // CPU wants the lines driven on a data beat with oe_n low
   assign rd_drive_o = !oe_n_s1 && lba_n_s1;

endmodule

// ==== eim/eim_readback.sv ====
// read side of the EIM bus: retimes the decoded read word toward the pads
// and registers the enable for the shared data lines

module eim_readback (
   input  logic                    bclk_i,
   input  logic                    arst_n_i,
   input  gpbb_bus_pkg::eim_data_t rd_data_i,
   input  logic                    rd_drive_i,
   output gpbb_bus_pkg::eim_data_t da_o,
   output logic                    da_oe_o
);

   import gpbb_bus_pkg::*;

   // retiming chain, index 0 sits next to the decode
   eim_data_t rd_pipe_q [EIM_RD_STAGES];

   // registered pad enable
   logic      da_oe_q;

   //////////////////////////////
   // read data retiming
   //////////////////////////////

   // the decode is a wide mux on the latched address
   // so it gets its own cycle before the pad register
   always_ff @(posedge bclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < EIM_RD_STAGES; i++) begin
            rd_pipe_q[i] <= '0;
         end
      end else begin
         rd_pipe_q[0] <= rd_data_i;
         // shift toward the pins
         for (int i = 1; i < EIM_RD_STAGES; i++) begin
            rd_pipe_q[i] <= rd_pipe_q[i-1];
         end
      end
   end

   // last stage drives the pads directly
   assign da_o = rd_pipe_q[EIM_RD_STAGES-1];

   //////////////////////////////
   // output enable
   //////////////////////////////

   // active high enable for the data lines
   // released as soon as oe_n rises or a new address phase starts
   // so the CPU never fights the FPGA on an address phase
   always_ff @(posedge bclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         da_oe_q <= 1'b0;
      end else begin
         da_oe_q <= rd_drive_i;
      end
   end

   assign da_oe_o = da_oe_q;

endmodule

// ==== verilog/gpbb_regs.sv ====
// register block of the breakout board: write-only control and DUT output words,
// synchronized DUT inputs and the read decode of the read-only bank

module gpbb_regs (
   input  logic                    bclk_i,
   input  logic                    arst_n_i,
   input  gpbb_bus_pkg::eim_addr_t bus_addr_i,
   input  gpbb_bus_pkg::eim_data_t wr_data_i,
   input  logic                    wr_stb_i,
   input  gpbb_map_pkg::dut_byte_t dut_in_i,
   input  logic                    overcurrent_i,
   output gpbb_bus_pkg::eim_data_t rd_data_o,
   output gpbb_map_pkg::dut_byte_t dut_a_o,
   output gpbb_map_pkg::dut_byte_t dut_b_o,
   output logic                    drive_a_n_o,
   output logic                    drive_b_n_o,
   output logic                    volt_sel_o
);

   import gpbb_bus_pkg::*;
   import gpbb_map_pkg::*;

   // write-only words
   eim_data_t ctl_q;
   eim_data_t dut_out_q;

   // synchronizer flops for the asynchronous board inputs
   dut_byte_t dut_in_meta;
   dut_byte_t dut_in_sync;
   logic      oc_meta;
   logic      oc_sync;

   // read-only words built from the synchronized inputs
   eim_data_t dut_in_word;
   eim_data_t stat_word;
   eim_data_t rd_data;

   //////////////////////////////
   // write-only bank
   //////////////////////////////

   // each word takes the full bus word on a strobed write to its address
   // anything else in the window is silently dropped
   always_ff @(posedge bclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctl_q     <= '0;
         dut_out_q <= '0;
      end else if (wr_stb_i) begin
         if (bus_addr_i == ADDR_CTL) begin
            ctl_q <= wr_data_i;
         end
         if (bus_addr_i == ADDR_DUT_OUT) begin
            dut_out_q <= wr_data_i;
         end
      end
   end

   // low byte to bank A, high byte to bank B
   assign dut_a_o = dut_out_q[DUT_BYTE_W-1:0];
   assign dut_b_o = dut_out_q[EIM_DATA_W-1:DUT_BYTE_W];

   // board pins are active low or inverted
   // so software writes 1 to enable and a cleared word is the safe state
   assign drive_a_n_o = !ctl_q[CTL_DRIVE_A];
   assign drive_b_n_o = !ctl_q[CTL_DRIVE_B];
   // 1 on the pin = low voltage
   assign volt_sel_o  = !ctl_q[CTL_HIGH_V];

   //////////////////////////////
   // input synchronizers
   //////////////////////////////

   // DUT pins and the overcurrent flag come from off board
   // two flops each before anything on bclk looks at them
   always_ff @(posedge bclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dut_in_meta <= '0;
         dut_in_sync <= '0;
         oc_meta     <= 1'b0;
         oc_sync     <= 1'b0;
      end else begin
         dut_in_meta <= dut_in_i;
         dut_in_sync <= dut_in_meta;
         oc_meta     <= overcurrent_i;
         oc_sync     <= oc_meta;
      end
   end

   //////////////////////////////
   // read-only bank
   //////////////////////////////

   // input byte zero extended to a bus word
   assign dut_in_word = {{(EIM_DATA_W-DUT_BYTE_W){1'b0}}, dut_in_sync};

   // status word, unused bits read 0
   always_comb begin
      stat_word                   = '0;
      stat_word[STAT_OVERCURRENT] = oc_sync;
   end

   // full address compare, write-only and unmapped words read 0
   always_comb begin
      case (bus_addr_i)
         ADDR_DUT_IN:    rd_data = dut_in_word;
         ADDR_STAT:      rd_data = stat_word;
         ADDR_VER_MINOR: rd_data = VER_MINOR;
         ADDR_VER_MAJOR: rd_data = VER_MAJOR;
         default:        rd_data = '0;
      endcase
   end

   // retimed downstream in the readback path
   assign rd_data_o = rd_data;

endmodule

// ==== verilog/gpbb_top.sv ====
// top level of the breakout board FPGA: EIM front end, register block
// and readback path, all on the bus clock

module gpbb_top (
   input  logic                       bclk_i,
   input  logic                       arst_n_i,
   // EIM bus from the CPU
   input  logic                       cs_n_i,
   input  logic                       rw_i,
   input  logic                       lba_n_i,
   input  logic                       oe_n_i,
   input  gpbb_bus_pkg::eim_hi_addr_t a_i,
   input  gpbb_bus_pkg::eim_data_t    da_i,
   output gpbb_bus_pkg::eim_data_t    da_o,
   output logic                       da_oe_o,
   // expansion connector
   input  gpbb_map_pkg::dut_byte_t    dut_in_i,
   input  logic                       overcurrent_i,
   output gpbb_map_pkg::dut_byte_t    dut_a_o,
   output gpbb_map_pkg::dut_byte_t    dut_b_o,
   output logic                       drive_a_n_o,
   output logic                       drive_b_n_o,
   output logic                       volt_sel_o
);

   import gpbb_bus_pkg::*;

   // front end to register block
   eim_addr_t bus_addr;
   eim_data_t wr_data;
   logic      wr_stb;

   // register block to readback
   eim_data_t rd_data;

   // front end to readback
   logic      rd_drive;

   //////////////////////////////
   // EIM front end
   //////////////////////////////

   eim_capture u_capture (
      .bclk_i     (bclk_i),
      .arst_n_i   (arst_n_i),
      .cs_n_i     (cs_n_i),
      .rw_i       (rw_i),
      .lba_n_i    (lba_n_i),
      .oe_n_i     (oe_n_i),
      .a_i        (a_i),
      .da_i       (da_i),
      .bus_addr_o (bus_addr),
      .wr_data_o  (wr_data),
      .wr_stb_o   (wr_stb),
      .rd_drive_o (rd_drive)
   );

   //////////////////////////////
   // register block
   //////////////////////////////

   gpbb_regs u_regs (
      .bclk_i        (bclk_i),
      .arst_n_i      (arst_n_i),
      .bus_addr_i    (bus_addr),
      .wr_data_i     (wr_data),
      .wr_stb_i      (wr_stb),
      .dut_in_i      (dut_in_i),
      .overcurrent_i (overcurrent_i),
      .rd_data_o     (rd_data),
      .dut_a_o       (dut_a_o),
      .dut_b_o       (dut_b_o),
      .drive_a_n_o   (drive_a_n_o),
      .drive_b_n_o   (drive_b_n_o),
      .volt_sel_o    (volt_sel_o)
   );

   // read data and pad enable back to the bus
   eim_readback u_readback (
      .bclk_i     (bclk_i),
      .arst_n_i   (arst_n_i),
      .rd_data_i  (rd_data),
      .rd_drive_i (rd_drive),
      .da_o       (da_o),
      .da_oe_o    (da_oe_o)
   );

endmodule

// ==== verif/gpbb_tb.sv ====
// table-driven testbench for the breakout board register block on the EIM bus
// each table row is one bus cycle followed by idle clocks and a pin check

module gpbb_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import gpbb_bus_pkg::*;
   import gpbb_map_pkg::*;

   typedef enum logic {OP_WR, OP_RD} bus_op_e;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_TESTS    = 16;
   localparam int DATA_BEATS   = 5;
   localparam int IDLE_CYCLES  = 4;
   // address phase + data beats + idle gap
   localparam int TEST_CYCLES  = 1 + DATA_BEATS + IDLE_CYCLES;
   localparam int SLACK_CYCLES = 10;
   localparam int WATCHDOG_NS  =
      (NUM_TESTS * TEST_CYCLES + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD;
   localparam int unsigned SEED = 32'h24d7_d860;

   // addresses outside the register map
   localparam eim_addr_t ADDR_UNMAPPED_LO = 19'h0_0004;
   localparam eim_addr_t ADDR_UNMAPPED_RO = 19'h4_1004;

   logic         bclk_i = 1'b0;
   logic         arst_n_i;
   logic         cs_n_i;
   logic         rw_i;
   logic         lba_n_i;
   logic         oe_n_i;
   eim_hi_addr_t a_i;
   eim_data_t    da_i;
   eim_data_t    da_o;
   logic         da_oe_o;
   dut_byte_t    dut_in_i;
   logic         overcurrent_i;
   dut_byte_t    dut_a_o;
   dut_byte_t    dut_b_o;
   logic         drive_a_n_o;
   logic         drive_b_n_o;
   logic         volt_sel_o;

   // stimulus table, inputs are {overcurrent, dut byte}
   bus_op_e      op_tab   [NUM_TESTS];
   eim_addr_t    addr_tab [NUM_TESTS];
   eim_data_t    data_tab [NUM_TESTS];
   eim_data_t    exp_tab  [NUM_TESTS];
   logic [8:0]   in_tab   [NUM_TESTS];
   string        name_tab [NUM_TESTS];

   // last word written to each write-only register
   eim_data_t    exp_ctl;
   eim_data_t    exp_dut_out;

   int           checks;
   int           errors;

   gpbb_top dut_i (
      .bclk_i        (bclk_i),
      .arst_n_i      (arst_n_i),
      .cs_n_i        (cs_n_i),
      .rw_i          (rw_i),
      .lba_n_i       (lba_n_i),
      .oe_n_i        (oe_n_i),
      .a_i           (a_i),
      .da_i          (da_i),
      .da_o          (da_o),
      .da_oe_o       (da_oe_o),
      .dut_in_i      (dut_in_i),
      .overcurrent_i (overcurrent_i),
      .dut_a_o       (dut_a_o),
      .dut_b_o       (dut_b_o),
      .drive_a_n_o   (drive_a_n_o),
      .drive_b_n_o   (drive_b_n_o),
      .volt_sel_o    (volt_sel_o)
   );

   always #(CLK_PERIOD / 2) bclk_i = ~bclk_i;

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic compare_word(input string name, input eim_data_t expected,
                               input eim_data_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // pins follow the inverted control bits and the two DUT bytes
   task automatic check_pins(input string name);
      compare_word({name, " drive_a_n"}, {15'h0, ~exp_ctl[CTL_DRIVE_A]}, {15'h0, drive_a_n_o});
      compare_word({name, " drive_b_n"}, {15'h0, ~exp_ctl[CTL_DRIVE_B]}, {15'h0, drive_b_n_o});
      compare_word({name, " volt_sel"}, {15'h0, ~exp_ctl[CTL_HIGH_V]}, {15'h0, volt_sel_o});
      compare_word({name, " dut_a"}, {8'h00, exp_dut_out[7:0]}, {8'h00, dut_a_o});
      compare_word({name, " dut_b"}, {8'h00, exp_dut_out[15:8]}, {8'h00, dut_b_o});
   endtask

   task automatic set_entry(input int idx, input bus_op_e op, input eim_addr_t addr,
                            input eim_data_t data, input eim_data_t expected,
                            input string name);
      op_tab[idx]   = op;
      addr_tab[idx] = addr;
      data_tab[idx] = data;
      exp_tab[idx]  = expected;
      name_tab[idx] = name;
   endtask

   task automatic build_table();
      int i;
      for (i = 0; i < NUM_TESTS; i++) begin
         in_tab[i] = 9'($urandom());
      end
      // flag forced both ways for the status reads
      in_tab[6][8] = 1'b1;
      in_tab[7][8] = 1'b0;
      set_entry(0, OP_RD, ADDR_VER_MINOR, 16'h0, 16'h0003, "version minor");
      set_entry(1, OP_RD, ADDR_VER_MAJOR, 16'h0, 16'h000B, "version major");
      set_entry(2, OP_WR, ADDR_CTL, 16'($urandom()), 16'h0, "control write");
      set_entry(3, OP_WR, ADDR_DUT_OUT, 16'($urandom()), 16'h0, "dut output write");
      set_entry(4, OP_RD, ADDR_DUT_IN, 16'h0, {8'h00, in_tab[4][7:0]}, "dut input read");
      set_entry(5, OP_RD, ADDR_STAT, 16'h0, {15'h0, in_tab[5][8]}, "status read");
      set_entry(6, OP_RD, ADDR_STAT, 16'h0, 16'h0001, "status flag set");
      set_entry(7, OP_RD, ADDR_STAT, 16'h0, 16'h0000, "status flag clear");
      set_entry(8, OP_RD, ADDR_UNMAPPED_LO, 16'h0, 16'h0, "unmapped low read");
      set_entry(9, OP_RD, ADDR_UNMAPPED_RO, 16'h0, 16'h0, "unmapped read-only read");
      set_entry(10, OP_WR, ADDR_STAT, 16'($urandom()), 16'h0, "status write ignored");
      set_entry(11, OP_WR, ADDR_VER_MAJOR, 16'($urandom()), 16'h0, "version write ignored");
      set_entry(12, OP_WR, ADDR_CTL, 16'($urandom()), 16'h0, "second control write");
      set_entry(13, OP_RD, ADDR_DUT_IN, 16'h0, {8'h00, in_tab[13][7:0]}, "second input read");
      set_entry(14, OP_WR, ADDR_DUT_OUT, 16'($urandom()), 16'h0, "second output write");
      set_entry(15, OP_WR, ADDR_CTL, 16'h8003, 16'h0, "control all enabled");
   endtask

   //////////////////////////////
   // bus cycles
   //////////////////////////////

   // address phase then write beats, the data lines stay released
   task automatic bus_write(input eim_addr_t addr, input eim_data_t data, input string name);
      int beat;
      @(negedge bclk_i);
      cs_n_i  = 1'b0;
      rw_i    = 1'b0;
      lba_n_i = 1'b0;
      oe_n_i  = 1'b1;
      a_i     = addr[EIM_ADDR_W-1:EIM_ADDR_LO_BITS];
      da_i    = addr[EIM_ADDR_LO_BITS-1:0];
      for (beat = 0; beat < DATA_BEATS; beat++) begin
         @(negedge bclk_i);
         lba_n_i = 1'b1;
         da_i    = data;
         compare_word({name, " enable during write"}, 16'h0, {15'h0, da_oe_o});
      end
   endtask

   // read word and enable are taken on the last beat
   task automatic bus_read(input eim_addr_t addr, output eim_data_t data, output logic oe);
      int beat;
      @(negedge bclk_i);
      cs_n_i  = 1'b0;
      rw_i    = 1'b1;
      lba_n_i = 1'b0;
      oe_n_i  = 1'b1;
      a_i     = addr[EIM_ADDR_W-1:EIM_ADDR_LO_BITS];
      da_i    = addr[EIM_ADDR_LO_BITS-1:0];
      for (beat = 0; beat < DATA_BEATS; beat++) begin
         @(negedge bclk_i);
         lba_n_i = 1'b1;
         oe_n_i  = 1'b0;
         da_i    = '0;
      end
      data = da_o;
      oe   = da_oe_o;
   endtask

   task automatic bus_idle();
      int cyc;
      for (cyc = 0; cyc < IDLE_CYCLES; cyc++) begin
         @(negedge bclk_i);
         cs_n_i  = 1'b1;
         rw_i    = 1'b1;
         lba_n_i = 1'b1;
         oe_n_i  = 1'b1;
         a_i     = '0;
         da_i    = '0;
      end
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      int unsigned seed_val;
      int          t;
      eim_data_t   rd_word;
      logic        rd_oe;
      arst_n_i      = 1'b0;
      cs_n_i        = 1'b1;
      rw_i          = 1'b1;
      lba_n_i       = 1'b1;
      oe_n_i        = 1'b1;
      a_i           = '0;
      da_i          = '0;
      dut_in_i      = '0;
      overcurrent_i = 1'b0;
      exp_ctl       = '0;
      exp_dut_out   = '0;
      checks        = 0;
      errors        = 0;
      seed_val      = $urandom(SEED);
      build_table();

      repeat (RESET_CYCLES) @(negedge bclk_i);
      arst_n_i = 1'b1;
      @(negedge bclk_i);
      // cleared control word means drivers off and low voltage
      compare_word("reset da_oe", 16'h0, {15'h0, da_oe_o});
      compare_word("reset da_o", 16'h0, da_o);
      check_pins("reset");

      for (t = 0; t < NUM_TESTS; t++) begin
         dut_in_i      = in_tab[t][7:0];
         overcurrent_i = in_tab[t][8];
         if (op_tab[t] == OP_WR) begin
            bus_write(addr_tab[t], data_tab[t], name_tab[t]);
            // only the two write-only words take the data
            if (addr_tab[t] == ADDR_CTL) begin
               exp_ctl = data_tab[t];
            end else if (addr_tab[t] == ADDR_DUT_OUT) begin
               exp_dut_out = data_tab[t];
            end
         end else begin
            bus_read(addr_tab[t], rd_word, rd_oe);
            compare_word(name_tab[t], exp_tab[t], rd_word);
            compare_word({name_tab[t], " enable on read"}, 16'h0001, {15'h0, rd_oe});
         end
         bus_idle();
         compare_word({name_tab[t], " enable after idle"}, 16'h0, {15'h0, da_oe_o});
         check_pins(name_tab[t]);
      end

      $display("%0d checks run, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // bounded by the table length and the reset time
   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the test table finished");
      $display("tests failed");
      $finish;
   end

endmodule

// ==== gpbb.f ====
common/gpbb_bus_pkg.sv
common/gpbb_map_pkg.sv
eim/eim_capture.sv
eim/eim_readback.sv
verilog/gpbb_regs.sv
verilog/gpbb_top.sv
verif/gpbb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module gpbb_tb --Mdir obj_dir -o gpbb_sim -f gpbb.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/gpbb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
